// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/1ps -f files.f \
		--top-module ex_tb --Mdir obj_dir -o Vex_tb
	./obj_dir/Vex_tb | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: files.f
+incdir+logic
logic/ex_pkg.sv
logic/ex_decode.sv
logic/ex_alu.sv
logic/ex_branch.sv
logic/ex_writeback.sv
logic/ex_top.sv
tests/ex_tb.sv

// File: logic/ex_alu.sv
/*
 Execute stage ALU
 Add, subtract, signed and unsigned compare, logic and shift operations on
 the two decoded operands.
 */
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
	input  ex_pkg::ex_op_t op_i,
	output ex_pkg::word_t  result_o
);
	import ex_pkg::*;

	word_t      a;
	word_t      b;
	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	assign a     = op_i.operand_a;
	assign b     = op_i.operand_b;
	assign shamt = b[4:0];              // rv32 shifts use five bits
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;

	always_comb begin
		case (op_i.alu_op)
			ALU_ADD:  result_o = a + b;
			ALU_SUB:  result_o = a - b;
			ALU_SLT:  result_o = word_t'(lt_s);   // zero-extended flag
			ALU_SLTU: result_o = word_t'(lt_u);
			ALU_XOR:  result_o = a ^ b;
			ALU_OR:   result_o = a | b;
			ALU_AND:  result_o = a & b;
			ALU_SLL:  result_o = a << shamt;
			ALU_SRL:  result_o = a >> shamt;
			ALU_SRA:  result_o = word_t'($signed(a) >>> shamt);
			default:  result_o = '0;
		endcase
	end

	// decode must never hand an ALU instruction an out-of-range selector
	always_comb begin
		if (op_i.kind == KIND_ALU) begin
			assert (op_i.alu_op inside {ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR,
				ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA})
			else $error("alu: undefined operation selector %0h", op_i.alu_op);
		end
	end

endmodule

`default_nettype wire

// File: logic/ex_branch.sv
/*
 Execute stage branch unit
 Evaluates the branch condition and produces the taken flag, the link
 address and the next program counter.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_branch (
	input  ex_pkg::ex_op_t op_i,
	output ex_pkg::flow_t  flow_o
);
	import ex_pkg::*;

	logic  eq;
	logic  lt_s;
	logic  lt_u;
	logic  cond_met;
	logic  is_jalr;
	logic  taken;
	word_t base;
	word_t sum;
	word_t target;
	word_t link;

	//--------------------------------------------------------------------------
	// condition
	//--------------------------------------------------------------------------
	assign eq   = (op_i.operand_a == op_i.operand_b);
	assign lt_s = $signed(op_i.operand_a) < $signed(op_i.operand_b);
	assign lt_u = op_i.operand_a < op_i.operand_b;

	always_comb begin
		case (op_i.br_cond)
			BR_EQ:   cond_met = eq;
			BR_NE:   cond_met = !eq;
			BR_LT:   cond_met = lt_s;
			BR_GE:   cond_met = !lt_s;
			BR_LTU:  cond_met = lt_u;
			BR_GEU:  cond_met = !lt_u;
			default: cond_met = 1'b0;   // not a branch
		endcase
	end

	assign is_jalr = (op_i.kind == KIND_JALR);
	assign taken   = ((op_i.kind == KIND_BRANCH) && cond_met) ||
		(op_i.kind == KIND_JAL) || is_jalr;

	//--------------------------------------------------------------------------
	// target and next pc
	//--------------------------------------------------------------------------
	assign base   = is_jalr ? op_i.operand_a : op_i.pc;   // rs1 for jalr
	assign sum    = base + op_i.imm;
	assign target = is_jalr ? {sum[31:1], 1'b0} : sum;
	assign link   = op_i.pc + `EX_PC_STEP;

	assign flow_o.taken   = taken;
	assign flow_o.link    = link;
	assign flow_o.pc_next = taken ? target : link;

endmodule

`default_nettype wire

// File: logic/ex_decode.sv
/*
 Instruction decode for the execute stage
 Slices the RV32I fields, builds the immediates, selects the ALU operands
 and the operation or branch condition, and flags illegal encodings.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_decode (
	input  ex_pkg::word_t  inst_i,
	input  ex_pkg::word_t  pc_i,
	input  ex_pkg::word_t  rs1_data_i,
	input  ex_pkg::word_t  rs2_data_i,
	output ex_pkg::ex_op_t op_o
);
	import ex_pkg::*;

	//--------------------------------------------------------------------------
	// fields and immediates
	//--------------------------------------------------------------------------
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_addr_t  rd;
	word_t      imm_i;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;
	logic       is_reg;
	logic       f7_base;
	logic       f7_alt;
	logic       imm_ok;
	logic       reg_ok;
	alu_op_e    alu_sel;

	assign opcode  = inst_i[6:0];
	assign funct3  = inst_i[14:12];
	assign funct7  = inst_i[31:25];
	assign rd      = inst_i[11:7];

	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u = {inst_i[31:12], 12'h000};
	assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	assign is_reg  = (opcode == `EX_OPC_OP);
	assign f7_base = (funct7 == `EX_F7_BASE);
	assign f7_alt  = (funct7 == `EX_F7_ALT);

	// shift immediates carry funct7, other immediates are free
	assign imm_ok = ((funct3 != `EX_F3_SLL) && (funct3 != `EX_F3_SR)) || f7_base ||
		(f7_alt && (funct3 == `EX_F3_SR));
	assign reg_ok = f7_base ||
		(f7_alt && ((funct3 == `EX_F3_ADD_SUB) || (funct3 == `EX_F3_SR)));

	always_comb begin
		case (funct3)
			`EX_F3_ADD_SUB: alu_sel = (is_reg && f7_alt) ? ALU_SUB : ALU_ADD;
			`EX_F3_SLL:     alu_sel = ALU_SLL;
			`EX_F3_SLT:     alu_sel = ALU_SLT;
			`EX_F3_SLTU:    alu_sel = ALU_SLTU;
			`EX_F3_XOR:     alu_sel = ALU_XOR;
			`EX_F3_SR:      alu_sel = f7_alt ? ALU_SRA : ALU_SRL;
			`EX_F3_OR:      alu_sel = ALU_OR;
			default:        alu_sel = ALU_AND;   // funct3 111
		endcase
	end

	//--------------------------------------------------------------------------
	// opcode map
	//--------------------------------------------------------------------------
	always_comb begin
		op_o.kind      = KIND_ILLEGAL;   // kept unless an encoding matches
		op_o.alu_op    = ALU_ADD;
		op_o.br_cond   = BR_NONE;
		op_o.operand_a = rs1_data_i;
		op_o.operand_b = rs2_data_i;
		op_o.imm       = imm_i;
		op_o.pc        = pc_i;
		op_o.rd        = rd;

		case (opcode)
			`EX_OPC_OP_IMM: begin
				op_o.operand_b = imm_i;
				op_o.alu_op    = alu_sel;
				op_o.kind      = imm_ok ? KIND_ALU : KIND_ILLEGAL;
			end
			`EX_OPC_OP: begin
				op_o.alu_op = alu_sel;
				op_o.kind   = reg_ok ? KIND_ALU : KIND_ILLEGAL;
			end
			`EX_OPC_BRANCH: begin
				op_o.imm  = imm_b;
				op_o.kind = KIND_BRANCH;
				case (funct3)
					`EX_F3_BEQ:  op_o.br_cond = BR_EQ;
					`EX_F3_BNE:  op_o.br_cond = BR_NE;
					`EX_F3_BLT:  op_o.br_cond = BR_LT;
					`EX_F3_BGE:  op_o.br_cond = BR_GE;
					`EX_F3_BLTU: op_o.br_cond = BR_LTU;
					`EX_F3_BGEU: op_o.br_cond = BR_GEU;
					default:     op_o.kind    = KIND_ILLEGAL;
				endcase
			end
			`EX_OPC_JAL: begin
				op_o.imm  = imm_j;
				op_o.kind = KIND_JAL;
			end
			`EX_OPC_JALR: begin
				op_o.kind = (funct3 == `EX_F3_JALR) ? KIND_JALR : KIND_ILLEGAL;
			end
			`EX_OPC_LUI: begin
				op_o.imm       = imm_u;
				op_o.operand_a = '0;        // alu adds zero
				op_o.operand_b = imm_u;
				op_o.kind      = KIND_LUI;
			end
			`EX_OPC_AUIPC: begin
				op_o.imm       = imm_u;
				op_o.operand_a = pc_i;
				op_o.operand_b = imm_u;
				op_o.kind      = KIND_AUIPC;
			end
			default: begin
				op_o.kind = KIND_ILLEGAL;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: logic/ex_pkg.sv
/*
 Execute stage types
 Data word, register index, operation selectors and the records passed
 between decode, ALU, branch unit and write-back.
 */
`default_nettype none

`include "ex_settings.svh"

package ex_pkg;

	typedef logic [`EX_XLEN-1:0]       word_t;
	typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_LT,
		BR_GE,
		BR_LTU,
		BR_GEU
	} br_cond_e;

	typedef enum logic [2:0] {
		KIND_ALU,
		KIND_BRANCH,
		KIND_JAL,
		KIND_JALR,
		KIND_LUI,
		KIND_AUIPC,
		KIND_ILLEGAL
	} op_kind_e;

	// one decoded instruction
	typedef struct packed {
		op_kind_e  kind;
		alu_op_e   alu_op;
		br_cond_e  br_cond;
		word_t     operand_a;   // rs1, zero or pc
		word_t     operand_b;   // rs2 or immediate
		word_t     imm;         // offset for branch and jump targets
		word_t     pc;
		reg_addr_t rd;
	} ex_op_t;

	typedef struct packed {
		logic  taken;
		word_t link;            // return address for jal and jalr
		word_t pc_next;
	} flow_t;

endpackage

`default_nettype wire

// File: logic/ex_settings.svh
/*
 RV32I execute stage settings
 Word and register index widths, the sequential PC step and the opcode and
 function codes of the supported integer instructions.
 */
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

`define EX_XLEN         32
`define EX_REG_ADDR_W   5
`define EX_PC_STEP      4            // one 32-bit instruction

// major opcodes, inst[6:0]
`define EX_OPC_OP_IMM   7'b0010011
`define EX_OPC_OP       7'b0110011
`define EX_OPC_BRANCH   7'b1100011
`define EX_OPC_JAL      7'b1101111
`define EX_OPC_JALR     7'b1100111
`define EX_OPC_LUI      7'b0110111
`define EX_OPC_AUIPC    7'b0010111

// alu funct3, shared by OP and OP_IMM
`define EX_F3_ADD_SUB   3'b000
`define EX_F3_SLL       3'b001
`define EX_F3_SLT       3'b010
`define EX_F3_SLTU      3'b011
`define EX_F3_XOR       3'b100
`define EX_F3_SR        3'b101       // srl and sra
`define EX_F3_OR        3'b110
`define EX_F3_AND       3'b111

// branch and jalr funct3
`define EX_F3_BEQ       3'b000
`define EX_F3_BNE       3'b001
`define EX_F3_BLT       3'b100
`define EX_F3_BGE       3'b101
`define EX_F3_BLTU      3'b110
`define EX_F3_BGEU      3'b111
`define EX_F3_JALR      3'b000

`define EX_F7_BASE      7'b0000000
`define EX_F7_ALT       7'b0100000   // sub and sra

`endif

// File: logic/ex_top.sv
/*
 RV32I integer execute stage
 One instruction per cycle in, register write and next pc out one cycle
 later.
 */
`timescale 1ns/1ps
`default_nettype none

module ex_top (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              valid_i,
	input  ex_pkg::word_t     inst_i,
	input  ex_pkg::word_t     pc_i,
	input  ex_pkg::word_t     rs1_data_i,
	input  ex_pkg::word_t     rs2_data_i,
	output logic              valid_o,
	output logic              rd_we_o,
	output ex_pkg::reg_addr_t rd_addr_o,
	output ex_pkg::word_t     rd_wdata_o,
	output ex_pkg::word_t     pc_next_o,
	output logic              jump_o,
	output logic              illegal_o
);
	import ex_pkg::*;

	ex_op_t ex_op;        // decoded instruction, combinational
	word_t  alu_result;
	flow_t  flow;

	ex_decode u_decode (
		.inst_i     (inst_i),
		.pc_i       (pc_i),
		.rs1_data_i (rs1_data_i),
		.rs2_data_i (rs2_data_i),
		.op_o       (ex_op)
	);

	ex_alu u_alu (
		.op_i     (ex_op),
		.result_o (alu_result)
	);

	ex_branch u_branch (
		.op_i   (ex_op),
		.flow_o (flow)
	);

	ex_writeback u_writeback (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.valid_i      (valid_i),
		.op_i         (ex_op),
		.alu_result_i (alu_result),
		.flow_i       (flow),
		.valid_o      (valid_o),
		.rd_we_o      (rd_we_o),
		.jump_o       (jump_o),
		.illegal_o    (illegal_o),
		.rd_addr_o    (rd_addr_o),
		.rd_wdata_o   (rd_wdata_o),
		.pc_next_o    (pc_next_o)
	);

endmodule

`default_nettype wire

// File: logic/ex_writeback.sv
/*
 Execute stage write-back
 Picks the register write value and enable, and registers every result
 together with the valid strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module ex_writeback (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              valid_i,
	input  ex_pkg::ex_op_t    op_i,
	input  ex_pkg::word_t     alu_result_i,
	input  ex_pkg::flow_t     flow_i,
	output logic              valid_o,
	output logic              rd_we_o,
	output logic              jump_o,
	output logic              illegal_o,
	output ex_pkg::reg_addr_t rd_addr_o,
	output ex_pkg::word_t     rd_wdata_o,
	output ex_pkg::word_t     pc_next_o
);
	import ex_pkg::*;

	logic  is_link;
	logic  is_illegal;
	logic  we;
	word_t wdata;

	assign is_link    = (op_i.kind == KIND_JAL) || (op_i.kind == KIND_JALR);
	assign is_illegal = (op_i.kind == KIND_ILLEGAL);
	assign we         = !((op_i.kind == KIND_BRANCH) || is_illegal);
	assign wdata      = is_link ? flow_i.link : alu_result_i;

	// strobes follow valid_i every cycle
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			valid_o   <= 1'b0;
			rd_we_o   <= 1'b0;
			jump_o    <= 1'b0;
			illegal_o <= 1'b0;
		end else begin
			valid_o   <= valid_i;
			rd_we_o   <= valid_i && we;
			jump_o    <= valid_i && flow_i.taken;
			illegal_o <= valid_i && is_illegal;
		end
	end

	// data holds while idle
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			rd_addr_o  <= '0;
			rd_wdata_o <= '0;
			pc_next_o  <= '0;
		end else if (valid_i) begin
			rd_addr_o  <= op_i.rd;
			rd_wdata_o <= wdata;
			pc_next_o  <= flow_i.pc_next;
		end
	end

	// decode, branch unit and this stage must agree on what an illegal op does
	a_we_not_illegal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		illegal_o |-> (!rd_we_o && !jump_o));

	a_jump_is_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		jump_o |-> valid_o);

endmodule

`default_nettype wire

// File: tests/ex_tb.sv
/*
 Testbench for the RV32I execute stage
 Applies a table of encoded instructions with an LFSR-chosen number of idle
 cycles between them and checks every registered result one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

module ex_tb;
	import ex_pkg::*;

	typedef struct packed {
		word_t     inst;
		word_t     pc;
		word_t     rs1;
		word_t     rs2;
		logic [2:0] flags;    // rd_we, jump, illegal
		reg_addr_t rd;
		word_t     wdata;
		word_t     pc_next;
	} vec_t;

	logic      clk_i = 1'b0;
	logic      rst_n_i;
	logic      valid_i;
	word_t     inst_i;
	word_t     pc_i;
	word_t     rs1_data_i;
	word_t     rs2_data_i;
	logic      valid_o;
	logic      rd_we_o;
	reg_addr_t rd_addr_o;
	word_t     rd_wdata_o;
	word_t     pc_next_o;
	logic      jump_o;
	logic      illegal_o;

	vec_t        vec_q[$];
	logic [31:0] lfsr = 32'h7863_ea2a;
	word_t       held_pc;

	ex_top u_dut (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.valid_i    (valid_i),
		.inst_i     (inst_i),
		.pc_i       (pc_i),
		.rs1_data_i (rs1_data_i),
		.rs2_data_i (rs2_data_i),
		.valid_o    (valid_o),
		.rd_we_o    (rd_we_o),
		.rd_addr_o  (rd_addr_o),
		.rd_wdata_o (rd_wdata_o),
		.pc_next_o  (pc_next_o),
		.jump_o     (jump_o),
		.illegal_o  (illegal_o)
	);

	always #5 clk_i = ~clk_i;   // 10 ns period

	//--------------------------------------------------------------------------
	// instruction encoders, rs1 = x1 and rs2 = x2
	//--------------------------------------------------------------------------
	function automatic word_t enc_i(input logic [11:0] imm, input logic [2:0] f3,
		input logic [4:0] rd, input logic [6:0] opc);
		enc_i = {imm, 5'd1, f3, rd, opc};
	endfunction

	function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd);
		enc_r = {f7, 5'd2, 5'd1, f3, rd, 7'h33};
	endfunction

	function automatic word_t enc_b(input logic [12:0] off, input logic [2:0] f3);
		enc_b = {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'h63};
	endfunction

	function automatic word_t enc_j(input logic [20:0] off, input logic [4:0] rd);
		enc_j = {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
	endfunction

	// galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bit(output logic b);
		b = lfsr[0];
		lfsr = lfsr_next(lfsr);
	endtask

	task automatic add_vec(input word_t inst, pc, rs1, rs2, input logic [2:0] flags,
		input reg_addr_t rd, input word_t wdata, pc_next);
		vec_t v;
		v.inst    = inst;
		v.pc      = pc;
		v.rs1     = rs1;
		v.rs2     = rs2;
		v.flags   = flags;
		v.rd      = rd;
		v.wdata   = wdata;
		v.pc_next = pc_next;
		vec_q.push_back(v);
	endtask

	//--------------------------------------------------------------------------
	// stimulus table: inst, pc, rs1, rs2, flags, rd, wdata, pc_next
	//--------------------------------------------------------------------------
	task automatic fill_table();
		add_vec(enc_i(12'hff0, 3'd0, 5'd1, 7'h13), 'h1000, 5, 0, 3'b100, 5'd1, -11, 'h1004);
		add_vec(enc_i(12'h001, 3'd2, 5'd2, 7'h13), 'h1004, -1, 0, 3'b100, 5'd2, 1, 'h1008);
		add_vec(enc_i(12'h001, 3'd3, 5'd3, 7'h13), 'h1008, -1, 0, 3'b100, 5'd3, 0, 'h100c);
		add_vec(enc_i(12'hfff, 3'd3, 5'd4, 7'h13), 'h100c, 1, 0, 3'b100, 5'd4, 1, 'h1010);
		add_vec(enc_i(12'hfff, 3'd2, 5'd5, 7'h13), 'h1010, 1, 0, 3'b100, 5'd5, 0, 'h1014);
		add_vec(enc_i(12'h0f0, 3'd4, 5'd6, 7'h13), 'h1014, 'hff, 0, 3'b100, 5'd6, 'h0f, 'h1018);
		add_vec(enc_i(12'h00f, 3'd6, 5'd7, 7'h13), 'h1018, 'hf00, 0, 3'b100, 5'd7, 'hf0f, 'h101c);
		add_vec(enc_i(12'hff0, 3'd7, 5'd8, 7'h13), 'h101c, 'h12345678, 0, 3'b100, 5'd8,
			'h12345670, 'h1020);
		add_vec(enc_i(12'h004, 3'd1, 5'd9, 7'h13), 'h1020, 'h80000001, 0, 3'b100, 5'd9,
			'h10, 'h1024);
		add_vec(enc_i(12'h004, 3'd5, 5'd10, 7'h13), 'h1024, 'h80000000, 0, 3'b100, 5'd10,
			'h08000000, 'h1028);
		add_vec(enc_i(12'h404, 3'd5, 5'd11, 7'h13), 'h1028, 'h80000000, 0, 3'b100, 5'd11,
			'hf8000000, 'h102c);
		// register-register forms
		add_vec(enc_r(7'h00, 3'd0, 5'd12), 'h102c, 'h7fffffff, 1, 3'b100, 5'd12,
			'h80000000, 'h1030);
		add_vec(enc_r(7'h20, 3'd0, 5'd13), 'h1030, 3, 5, 3'b100, 5'd13, -2, 'h1034);
		add_vec(enc_r(7'h00, 3'd1, 5'd14), 'h1034, 1, 'h23, 3'b100, 5'd14, 8, 'h1038);
		add_vec(enc_r(7'h00, 3'd2, 5'd15), 'h1038, 'h80000000, 1, 3'b100, 5'd15, 1, 'h103c);
		add_vec(enc_r(7'h00, 3'd3, 5'd16), 'h103c, 'h80000000, 1, 3'b100, 5'd16, 0, 'h1040);
		add_vec(enc_r(7'h00, 3'd4, 5'd17), 'h1040, 'hff00ff00, 'h0ff00ff0, 3'b100, 5'd17,
			'hf0f0f0f0, 'h1044);
		add_vec(enc_r(7'h00, 3'd5, 5'd18), 'h1044, 'hf0000000, 8, 3'b100, 5'd18,
			'h00f00000, 'h1048);
		add_vec(enc_r(7'h20, 3'd5, 5'd19), 'h1048, 'hf0000000, 8, 3'b100, 5'd19,
			'hfff00000, 'h104c);
		add_vec(enc_r(7'h00, 3'd6, 5'd20), 'h104c, 'h0000ff00, 'h00ff0000, 3'b100, 5'd20,
			'h00ffff00, 'h1050);
		add_vec(enc_r(7'h00, 3'd7, 5'd21), 'h1050, 'hff00ff00, 'h0ff00ff0, 3'b100, 5'd21,
			'h0f000f00, 'h1054);
		// branches, each taken then not taken
		add_vec(enc_b(13'h0010, 3'd0), 'h200, 7, 7, 3'b010, 5'd0, 0, 'h210);
		add_vec(enc_b(13'h0010, 3'd0), 'h200, 7, 8, 3'b000, 5'd0, 0, 'h204);
		add_vec(enc_b(13'h1ff0, 3'd1), 'h300, 1, 2, 3'b010, 5'd0, 0, 'h2f0);
		add_vec(enc_b(13'h1ff0, 3'd1), 'h300, 5, 5, 3'b000, 5'd0, 0, 'h304);
		add_vec(enc_b(13'h0020, 3'd4), 'h400, -1, 1, 3'b010, 5'd0, 0, 'h420);
		add_vec(enc_b(13'h0020, 3'd4), 'h400, 1, -1, 3'b000, 5'd0, 0, 'h404);
		add_vec(enc_b(13'h1f00, 3'd5), 'h500, 1, -1, 3'b010, 5'd0, 0, 'h400);
		add_vec(enc_b(13'h1f00, 3'd5), 'h500, -1, 1, 3'b000, 5'd0, 0, 'h504);
		add_vec(enc_b(13'h0040, 3'd6), 'h600, 1, -1, 3'b010, 5'd0, 0, 'h640);
		add_vec(enc_b(13'h0040, 3'd6), 'h600, -1, 1, 3'b000, 5'd0, 0, 'h604);
		add_vec(enc_b(13'h0800, 3'd7), 'h700, -1, 1, 3'b010, 5'd0, 0, 'hf00);
		add_vec(enc_b(13'h0800, 3'd7), 'h700, 1, -1, 3'b000, 5'd0, 0, 'h704);
		// jumps and upper immediates
		add_vec(enc_j(21'h1ff000, 5'd1), 'h2000, 0, 0, 3'b110, 5'd1, 'h2004, 'h1000);
		add_vec(enc_i(12'h011, 3'd0, 5'd5, 7'h67), 'h900, 'h3000, 0, 3'b110, 5'd5,
			'h904, 'h3010);
		add_vec({20'h12345, 5'd6, 7'h37}, 'ha00, 'hdead, 0, 3'b100, 5'd6, 'h12345000, 'ha04);
		add_vec({20'hfffff, 5'd7, 7'h17}, 'hb00, 0, 0, 3'b100, 5'd7, 'hfffffb00, 'hb04);
		// load opcode and an OP with funct7 0000001
		add_vec(enc_i(12'h004, 3'd2, 5'd8, 7'h03), 'hc00, 0, 0, 3'b001, 5'd8, 0, 'hc04);
		add_vec(enc_r(7'h01, 3'd0, 5'd9), 'hc04, 3, 4, 3'b001, 5'd9, 0, 'hc08);
	endtask

	//--------------------------------------------------------------------------
	// checks
	//--------------------------------------------------------------------------
	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Some tests failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic check_result(input vec_t v);
		compare("valid_o", 32'(valid_o), 1);
		compare("rd_we_o", 32'(rd_we_o), 32'(v.flags[2]));
		compare("jump_o", 32'(jump_o), 32'(v.flags[1]));
		compare("illegal_o", 32'(illegal_o), 32'(v.flags[0]));
		compare("pc_next_o", pc_next_o, v.pc_next);
		if (v.flags[2]) begin    // rd fields only matter on a write
			compare("rd_addr_o", 32'(rd_addr_o), 32'(v.rd));
			compare("rd_wdata_o", rd_wdata_o, v.wdata);
		end
	endtask

	task automatic check_idle();
		compare("valid_o", 32'(valid_o), 0);
		compare("rd_we_o", 32'(rd_we_o), 0);
		compare("jump_o", 32'(jump_o), 0);
		compare("illegal_o", 32'(illegal_o), 0);
		compare("pc_next_o", pc_next_o, held_pc);   // data holds while idle
	endtask

	//--------------------------------------------------------------------------
	// driving, inputs change 1 ns after the rising edge
	//--------------------------------------------------------------------------
	task automatic drive_vec(input vec_t v);
		valid_i    = 1'b1;
		inst_i     = v.inst;
		pc_i       = v.pc;
		rs1_data_i = v.rs1;
		rs2_data_i = v.rs2;
	endtask

	task automatic drive_idle();
		valid_i = 1'b0;
		@(posedge clk_i);
		#1;
		check_idle();
	endtask

	task automatic wait_for_valid(input int limit);
		int n;
		n = 0;
		do begin
			@(posedge clk_i);
			#1;
			valid_i = 1'b0;
			n++;
		end while (!valid_o && n < limit);
		if (!valid_o) begin
			$display("timeout: no valid output within %0d cycle(s) of the input", limit);
			$display("Some tests failed");
			$fatal(1, "timeout waiting for valid_o");
		end
	endtask

	initial begin
		int   gaps;
		logic b;
		rst_n_i    = 1'b0;
		valid_i    = 1'b0;
		inst_i     = '0;
		pc_i       = '0;
		rs1_data_i = '0;
		rs2_data_i = '0;
		held_pc    = '0;
		fill_table();

		repeat (16) @(posedge clk_i);
		#1;
		check_idle();
		compare("rd_wdata_o", rd_wdata_o, 0);
		rst_n_i = 1'b1;
		drive_idle();            // first cycle out of reset

		for (int i = 0; i < vec_q.size(); i++) begin
			take_bit(b);
			gaps = 0;
			if (b) begin
				take_bit(b);
				gaps = b ? 2 : 1;
			end
			repeat (gaps) drive_idle();
			drive_vec(vec_q[i]);
			wait_for_valid(1);   // latency is exactly one cycle
			check_result(vec_q[i]);
			held_pc = vec_q[i].pc_next;
		end
		drive_idle();

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire
